// ==== hdl/iirTypesPkg.sv ====
/*
 * Sample and coefficient definitions shared by the IIR filter datapath.
 * Imported by the stages, the coefficient banks and the top level.
 */
package iirTypesPkg;

    // Defaults for the top-level parameters
    localparam int DEFAULT_STAGES     = 3;
    localparam int DEFAULT_DATA_WIDTH = 16;
    localparam int DEFAULT_COEF_WIDTH = 25;

    // 24 high bits from the address word plus 31 low bits from the value word
    localparam int MAX_COEF_WIDTH = 55;

    // Integer part of a coefficient, sign included, covering -4 up to just under 4
    localparam int COEF_INT_BITS = 3;

    // Fraction bits that go with a given coefficient width
    function automatic int coefFracBits(input int coefWidth);
        return coefWidth - COEF_INT_BITS;
    endfunction

    // Coefficient slots, in the order the stage multiplies them
    typedef enum logic [2:0] {
        coefB0 = 3'd0,
        coefB1 = 3'd1,
        coefB2 = 3'd2,
        coefA1 = 3'd3,
        coefA2 = 3'd4
    } coefSlotT;

    // Biquad stage FSM
    typedef enum logic [1:0] {
        stIdle,   // Waiting for an input sample
        stMac,    // One product per cycle
        stRound,  // Round and saturate
        stHold    // Output valid, waiting for ready
    } stageStateT;

endpackage

// ==== hdl/gpioCmdPkg.sv ====
/*
 * Layout of the 32-bit host register word used to load coefficients.
 * Address words carry slot, stage and high bits; value words carry the low bits.
 */
package gpioCmdPkg;

    // Bit 31 selects the kind of word
    typedef enum logic {
        cmdAddress = 1'b0,
        cmdValue   = 1'b1
    } gpioKindT;

    localparam int KIND_BIT  = 31;
    localparam int SLOT_LSB  = 0;
    localparam int STAGE_LSB = 3;
    localparam int HIGH_LSB  = 8;

    // Field widths follow from the positions above
    localparam int SLOT_WIDTH  = STAGE_LSB - SLOT_LSB;
    localparam int STAGE_WIDTH = HIGH_LSB - STAGE_LSB;
    localparam int HIGH_WIDTH  = 32 - HIGH_LSB;

    // Low coefficient bits in a value word, all below the kind bit
    localparam int LOW_WIDTH = KIND_BIT;

endpackage

// ==== hdl/coefLoader.sv ====
/*
 * Decodes host register writes into coefficient writes for the filter stages.
 * An address word picks stage and slot, a value word completes and writes the value.
 */
module coefLoader #(
    parameter int STAGES            = iirTypesPkg::DEFAULT_STAGES,
    parameter int COEFFICIENT_WIDTH = iirTypesPkg::DEFAULT_COEF_WIDTH
) (
    input  logic                         sysClk,
    input  logic                         rst,
    input  logic                         gpioStrobe,
    input  logic [31:0]                  gpioData,
    output iirTypesPkg::coefSlotT        coefSlot,
    output logic [COEFFICIENT_WIDTH-1:0] coefValue,
    output logic [STAGES-1:0]            coefWrite
);
    import iirTypesPkg::*;
    import gpioCmdPkg::*;

    gpioKindT                  kind;
    coefSlotT                  slotSel;    // Latched from the address word
    logic [STAGE_WIDTH-1:0]    stageSel;
    logic [HIGH_WIDTH-1:0]     highBits;
    logic [MAX_COEF_WIDTH-1:0] fullCoef;
    logic [STAGES-1:0]         stageMask;

    assign kind     = gpioKindT'(gpioData[KIND_BIT]);
    assign fullCoef = {highBits, gpioData[LOW_WIDTH-1:0]};

    // Stage index out of range leaves the mask empty
    always_comb begin
        stageMask = '0;
        for (int s = 0; s < STAGES; s++) begin
            stageMask[s] = (int'(stageSel) == s);
        end
    end

    always_ff @(posedge sysClk) begin
        if (rst) begin
            slotSel   <= coefB0;
            stageSel  <= '0;
            highBits  <= '0;
            coefSlot  <= coefB0;
            coefWrite <= '0;
        end else begin
            coefWrite <= '0;   // Single-cycle pulse
            if (gpioStrobe && kind == cmdAddress) begin
                slotSel  <= coefSlotT'(gpioData[SLOT_LSB +: SLOT_WIDTH]);
                stageSel <= gpioData[STAGE_LSB +: STAGE_WIDTH];
                highBits <= gpioData[HIGH_LSB +: HIGH_WIDTH];
            end
            if (gpioStrobe && kind == cmdValue) begin
                coefSlot  <= slotSel;
                coefWrite <= stageMask;
            end
        end
    end

    // Value register, only meaningful while a write bit is high
    always_ff @(posedge sysClk) begin
        if (gpioStrobe && kind == cmdValue) begin
            coefValue <= fullCoef[COEFFICIENT_WIDTH-1:0];
        end
    end

endmodule

// ==== hdl/coefBank.sv ====
/*
 * Coefficient registers of one biquad stage.
 * A write strobe updates the register chosen by the slot code.
 */
module coefBank #(
    parameter int COEFFICIENT_WIDTH = iirTypesPkg::DEFAULT_COEF_WIDTH
) (
    input  logic                                sysClk,
    input  logic                                rst,
    input  logic                                coefWrite,
    input  iirTypesPkg::coefSlotT               coefSlot,
    input  logic [COEFFICIENT_WIDTH-1:0]        coefValue,
    output logic signed [COEFFICIENT_WIDTH-1:0] b0,
    output logic signed [COEFFICIENT_WIDTH-1:0] b1,
    output logic signed [COEFFICIENT_WIDTH-1:0] b2,
    output logic signed [COEFFICIENT_WIDTH-1:0] a1,
    output logic signed [COEFFICIENT_WIDTH-1:0] a2
);
    import iirTypesPkg::*;

    always_ff @(posedge sysClk) begin
        if (rst) begin
            // Zero coefficients give a silent stage
            b0 <= '0;
            b1 <= '0;
            b2 <= '0;
            a1 <= '0;
            a2 <= '0;
        end else if (coefWrite) begin
            case (coefSlot)
                coefB0:  b0 <= coefValue;
                coefB1:  b1 <= coefValue;
                coefB2:  b2 <= coefValue;
                coefA1:  a1 <= coefValue;
                coefA2:  a2 <= coefValue;
                default: ;   // Codes 5 to 7 do nothing
            endcase
        end
    end

endmodule

// ==== hdl/biquadStage.sv ====
/*
 * One direct-form-I biquad section with a single shared multiplier.
 * Accepts a sample in idle, runs five products, rounds and saturates,
 * then holds the result until the downstream side takes it.
 */
module biquadStage #(
    parameter int DATA_WIDTH        = iirTypesPkg::DEFAULT_DATA_WIDTH,
    parameter int COEFFICIENT_WIDTH = iirTypesPkg::DEFAULT_COEF_WIDTH
) (
    input  logic                         sysClk,
    input  logic                         rst,
    input  logic                         coefWrite,
    input  iirTypesPkg::coefSlotT        coefSlot,
    input  logic [COEFFICIENT_WIDTH-1:0] coefValue,
    input  logic signed [DATA_WIDTH-1:0] inData,
    input  logic                         inValid,
    output logic                         inReady,
    output logic signed [DATA_WIDTH-1:0] outData,
    output logic                         outValid,
    input  logic                         outReady
);
    import iirTypesPkg::*;

    localparam int COEF_FRAC_BITS = coefFracBits(COEFFICIENT_WIDTH);
    localparam int PROD_WIDTH     = DATA_WIDTH + COEFFICIENT_WIDTH;
    localparam int ACC_WIDTH      = PROD_WIDTH + 3;   // Room for five full products

    localparam logic signed [ACC_WIDTH-1:0] ROUND_HALF = ACC_WIDTH'(1) << (COEF_FRAC_BITS - 1);
    localparam logic signed [ACC_WIDTH-1:0] SAT_MAX =
        {{(ACC_WIDTH - DATA_WIDTH + 1){1'b0}}, {(DATA_WIDTH - 1){1'b1}}};
    localparam logic signed [ACC_WIDTH-1:0] SAT_MIN = ~SAT_MAX;

    stageStateT state;
    coefSlotT   macSlot;   // Product being accumulated

    logic signed [COEFFICIENT_WIDTH-1:0] b0, b1, b2, a1, a2;
    logic signed [DATA_WIDTH-1:0]        xCur, x1, x2, y1, y2;
    logic signed [COEFFICIENT_WIDTH-1:0] macCoef;
    logic signed [DATA_WIDTH-1:0]        macData;
    logic signed [PROD_WIDTH-1:0]        product;
    logic signed [ACC_WIDTH-1:0]         productExt;
    logic signed [ACC_WIDTH-1:0]         acc;
    logic signed [ACC_WIDTH-1:0]         rounded;
    logic signed [ACC_WIDTH-1:0]         shifted;
    logic signed [DATA_WIDTH-1:0]        satResult;

    coefBank #(
        .COEFFICIENT_WIDTH(COEFFICIENT_WIDTH)
    ) i_coefBank (
        .sysClk   (sysClk),
        .rst      (rst),
        .coefWrite(coefWrite),
        .coefSlot (coefSlot),
        .coefValue(coefValue),
        .b0       (b0),
        .b1       (b1),
        .b2       (b2),
        .a1       (a1),
        .a2       (a2)
    );

    assign inReady  = (state == stIdle);
    assign outValid = (state == stHold);

    // Operand select for the shared multiplier
    always_comb begin
        case (macSlot)
            coefB0:  begin macCoef = b0; macData = xCur; end
            coefB1:  begin macCoef = b1; macData = x1;   end
            coefB2:  begin macCoef = b2; macData = x2;   end
            coefA1:  begin macCoef = a1; macData = y1;   end
            coefA2:  begin macCoef = a2; macData = y2;   end
            default: begin macCoef = '0; macData = '0;   end
        endcase
    end

    assign product    = macCoef * macData;
    assign productExt = ACC_WIDTH'(product);

    // Round half up, then clip to the sample range
    always_comb begin
        rounded = acc + ROUND_HALF;
        shifted = rounded >>> COEF_FRAC_BITS;
        if (shifted > SAT_MAX) begin
            satResult = SAT_MAX[DATA_WIDTH-1:0];
        end else if (shifted < SAT_MIN) begin
            satResult = SAT_MIN[DATA_WIDTH-1:0];
        end else begin
            satResult = shifted[DATA_WIDTH-1:0];
        end
    end

    always_ff @(posedge sysClk) begin
        if (rst) begin
            state   <= stIdle;
            macSlot <= coefB0;
            x1      <= '0;
            x2      <= '0;
            y1      <= '0;
            y2      <= '0;
        end else begin
            case (state)
                stIdle: if (inValid) begin
                    macSlot <= coefB0;
                    state   <= stMac;
                end
                stMac: if (macSlot == coefA2) begin
                    state <= stRound;
                end else begin
                    macSlot <= coefSlotT'(macSlot + 3'd1);
                end
                stRound: state <= stHold;
                stHold: if (outReady) begin
                    // Histories advance only when the output is taken
                    x2    <= x1;
                    x1    <= xCur;
                    y2    <= y1;
                    y1    <= outData;
                    state <= stIdle;
                end
                default: state <= stIdle;
            endcase
        end
    end

    always_ff @(posedge sysClk) begin
        if (state == stIdle && inValid) begin
            xCur <= inData;
            acc  <= '0;
        end
        if (state == stMac) begin
            if (macSlot == coefA1 || macSlot == coefA2) acc <= acc - productExt;   // Feedback terms
            else acc <= acc + productExt;
        end
        if (state == stRound) outData <= satResult;
    end

endmodule

// ==== hdl/iirFilter.sv ====
/*
 * Cascaded IIR filter top level built from biquad stages.
 * Coefficients arrive through the host register, samples through a valid/ready stream.
 */
module iirFilter #(
    parameter int STAGES            = iirTypesPkg::DEFAULT_STAGES,
    parameter int DATA_WIDTH        = iirTypesPkg::DEFAULT_DATA_WIDTH,
    parameter int COEFFICIENT_WIDTH = iirTypesPkg::DEFAULT_COEF_WIDTH
) (
    input  logic                         sysClk,
    input  logic                         rst,
    input  logic                         gpioStrobe,
    input  logic [31:0]                  gpioData,
    input  logic signed [DATA_WIDTH-1:0] inData,
    input  logic                         inValid,
    output logic                         inReady,
    output logic signed [DATA_WIDTH-1:0] outData,
    output logic                         outValid,
    input  logic                         outReady
);
    import iirTypesPkg::*;

    coefSlotT                     coefSlot;   // Shared by all banks
    logic [COEFFICIENT_WIDTH-1:0] coefValue;
    logic [STAGES-1:0]            coefWrite;

    // Stream links, entry 0 is the filter input and entry STAGES the output
    logic signed [DATA_WIDTH-1:0] stageData [0:STAGES];
    logic [STAGES:0]              stageValid;
    logic [STAGES:0]              stageReady;

    assign stageData[0]       = inData;
    assign stageValid[0]      = inValid;
    assign inReady            = stageReady[0];
    assign outData            = stageData[STAGES];
    assign outValid           = stageValid[STAGES];
    assign stageReady[STAGES] = outReady;

    coefLoader #(
        .STAGES           (STAGES),
        .COEFFICIENT_WIDTH(COEFFICIENT_WIDTH)
    ) i_coefLoader (
        .sysClk    (sysClk),
        .rst       (rst),
        .gpioStrobe(gpioStrobe),
        .gpioData  (gpioData),
        .coefSlot  (coefSlot),
        .coefValue (coefValue),
        .coefWrite (coefWrite)
    );

    for (genvar i = 0; i < STAGES; i++) begin : gStage
        biquadStage #(
            .DATA_WIDTH       (DATA_WIDTH),
            .COEFFICIENT_WIDTH(COEFFICIENT_WIDTH)
        ) i_biquadStage (
            .sysClk   (sysClk),
            .rst      (rst),
            .coefWrite(coefWrite[i]),
            .coefSlot (coefSlot),
            .coefValue(coefValue),
            .inData   (stageData[i]),
            .inValid  (stageValid[i]),
            .inReady  (stageReady[i]),
            .outData  (stageData[i+1]),
            .outValid (stageValid[i+1]),
            .outReady (stageReady[i+1])
        );
    end

endmodule

// ==== tb/iirFilter_checker.sv ====
/*
 * Concurrent assertions on the filter output stream and coefficient write strobes.
 * Bound into iirFilter; each violation also bumps a counter the testbench reads.
 */
module iirFilter_checker #(
    parameter int STAGES     = 3,
    parameter int DATA_WIDTH = 16
) (
    input logic                  sysClk,
    input logic                  rst,
    input logic [DATA_WIDTH-1:0] outData,
    input logic                  outValid,
    input logic                  outReady,
    input logic [STAGES-1:0]     coefWrite
);
    timeunit 1ns;
    timeprecision 100ps;

    int violationCount = 0;

    // Stalled output must not move
    outputHeld: assert property (@(posedge sysClk) disable iff (rst)
        (outValid && !outReady) |=> (outValid && $stable(outData)))
    else begin
        violationCount++;
        $error("Output changed while stalled");
    end

    oneStageWrite: assert property (@(posedge sysClk) disable iff (rst) $onehot0(coefWrite))
    else begin
        violationCount++;
        $error("More than one stage written at once");
    end

    quietAfterReset: assert property (@(posedge sysClk) rst |=> !outValid)
    else begin
        violationCount++;
        $error("outValid high right after reset");
    end

endmodule

bind iirFilter iirFilter_checker #(
    .STAGES    (STAGES),
    .DATA_WIDTH(DATA_WIDTH)
) i_checker (
    .sysClk   (sysClk),
    .rst      (rst),
    .outData  (outData),
    .outValid (outValid),
    .outReady (outReady),
    .coefWrite(coefWrite)
);

// ==== tb/iirFilterTb.sv ====
/*
 * Directed testbench for the cascaded IIR filter.
 * Loads coefficients over the host register, streams samples and compares
 * every output against a fixed-point biquad model kept in the testbench.
 */
module iirFilterTb;
    timeunit 1ns;
    timeprecision 100ps;
    import iirTypesPkg::*;

    localparam int STAGES     = 3;
    localparam int DATA_WIDTH = 16;
    localparam int COEF_WIDTH = 40;   // Wider than 31, so address-word bits reach the bank
    localparam int COEF_FRAC  = COEF_WIDTH - 3;
    localparam longint ONE    = longint'(1) <<< COEF_FRAC;

    typedef logic signed [DATA_WIDTH-1:0] sampleT;

    logic        sysClk;
    logic        rst;
    logic        gpioStrobe;
    logic [31:0] gpioData;
    sampleT      inData;
    logic        inValid;
    logic        inReady;
    sampleT      outData;
    logic        outValid;
    logic        outReady;

    int     errorCount = 0;
    int     checkTotal = 0;
    longint coefModel [STAGES][5];
    longint x1M [STAGES];
    longint x2M [STAGES];
    longint y1M [STAGES];
    longint y2M [STAGES];
    sampleT stimQ[$];
    sampleT expectQ[$];
    sampleT resultQ[$];

    iirFilter #(
        .STAGES           (STAGES),
        .DATA_WIDTH       (DATA_WIDTH),
        .COEFFICIENT_WIDTH(COEF_WIDTH)
    ) i_iirFilter (.*);

    always #2 sysClk = ~sysClk;

    // Every drive and sample happens 1 ns after the rising edge
    task automatic tick();
        @(posedge sysClk);
        #1;
    endtask

    function automatic sampleT saturate(longint v);
        longint hi;
        longint lo;
        hi = (longint'(1) <<< (DATA_WIDTH - 1)) - 1;
        lo = -hi - 1;
        if (v > hi) return sampleT'(hi);
        if (v < lo) return sampleT'(lo);
        return sampleT'(v);
    endfunction

    // Direct form I, round half up, then clip
    function automatic sampleT modelStage(int s, sampleT x);
        longint acc;
        sampleT y;
        acc = coefModel[s][0] * x + coefModel[s][1] * x1M[s] + coefModel[s][2] * x2M[s]
            - coefModel[s][3] * y1M[s] - coefModel[s][4] * y2M[s];
        y = saturate((acc + (ONE >>> 1)) >>> COEF_FRAC);
        x2M[s] = x1M[s];
        x1M[s] = x;
        y2M[s] = y1M[s];
        y1M[s] = y;
        return y;
    endfunction

    function automatic sampleT modelFilter(sampleT x);
        sampleT v;
        v = x;
        for (int s = 0; s < STAGES; s++) v = modelStage(s, v);
        return v;
    endfunction

    task automatic checkSample(string name, sampleT expected, sampleT actual);
        checkTotal++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
        end
    endtask

    task automatic checkBit(string name, logic expected, logic actual);
        checkTotal++;
        if (expected !== actual) begin
            errorCount++;
            $display("FAILED %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic checkCount(string name, int expected, int actual);
        checkTotal++;
        if (actual < expected) begin
            errorCount++;
            $display("%s: %0d of %0d outputs never arrived", name, expected - actual, expected);
        end else if (actual > expected) begin
            errorCount++;
            $display("%s: %0d outputs more than samples sent", name, actual - expected);
        end
    endtask

    task automatic applyReset();
        rst        = 1'b1;
        inValid    = 1'b0;
        outReady   = 1'b1;
        gpioStrobe = 1'b0;
        repeat (5) tick();
        rst = 1'b0;
        for (int s = 0; s < STAGES; s++) begin
            for (int k = 0; k < 5; k++) begin
                coefModel[s][k] = 0;
            end
            x1M[s] = 0;
            x2M[s] = 0;
            y1M[s] = 0;
            y2M[s] = 0;
        end
    endtask

    task automatic writeCoef(int stage, coefSlotT slot, longint value);
        logic [54:0] full;
        full = '0;
        full[COEF_WIDTH-1:0] = value[COEF_WIDTH-1:0];
        gpioStrobe = 1'b1;
        gpioData   = {full[54:31], 5'(stage), 3'(slot)};   // Address word, bit 31 clear
        tick();
        gpioData = {1'b1, full[30:0]};                     // Value word
        tick();
        gpioStrobe = 1'b0;
        coefModel[stage][int'(slot)] = value;
    endtask

    task automatic loadStage(int stage, longint b0, longint b1, longint b2,
                             longint a1, longint a2);
        writeCoef(stage, coefB0, b0);
        writeCoef(stage, coefB1, b1);
        writeCoef(stage, coefB2, b2);
        writeCoef(stage, coefA1, a1);
        writeCoef(stage, coefA2, a2);
        repeat (2) tick();   // Loader register, then bank register
    endtask

    task automatic randomSamples(int n, int span);
        stimQ.delete();
        repeat (n) stimQ.push_back(sampleT'($urandom_range(0, 2 * span) - span));
    endtask

    task automatic sendAll();
        int waited;
        foreach (stimQ[i]) begin
            inData  = stimQ[i];
            inValid = 1'b1;
            waited  = 0;
            while (!inReady && waited < 200) begin
                tick();
                waited++;
            end
            if (!inReady) begin
                errorCount++;
                $display("Timeout: inReady stayed low for 200 cycles at sample %0d", i);
                break;
            end
            tick();   // Transfer on this edge
        end
        inValid = 1'b0;
    endtask

    task automatic collectAll(int count, bit stall);
        int idle;
        int stretch;
        bit ready;
        idle    = 0;
        stretch = 0;
        ready   = 1'b1;
        while (resultQ.size() < count && idle < 200) begin
            if (stall) begin
                if (stretch == 0) begin
                    ready   = !ready;
                    stretch = $urandom_range(1, 6);
                end
                stretch--;
            end
            outReady = ready;
            if (outValid && outReady) begin
                resultQ.push_back(outData);
                idle = 0;
            end else idle++;
            tick();
        end
        outReady = 1'b1;
        if (resultQ.size() < count) begin
            errorCount++;
            $display("Timeout: no output for 200 cycles");
        end
        repeat (30) begin   // Anything arriving now is extra
            if (outValid) resultQ.push_back(outData);
            tick();
        end
    endtask

    task automatic runSamples(string name, bit stall);
        expectQ.delete();
        resultQ.delete();
        foreach (stimQ[i]) expectQ.push_back(modelFilter(stimQ[i]));
        fork
            sendAll();
            collectAll(stimQ.size(), stall);
        join
        checkCount(name, expectQ.size(), resultQ.size());
        foreach (resultQ[i]) if (i < expectQ.size()) checkSample(name, expectQ[i], resultQ[i]);
    endtask

    task automatic loadCascade();
        loadStage(0, ONE * 3 / 8, ONE / 4, ONE / 8, -(ONE / 4), ONE / 8);
        loadStage(1, ONE / 2, -(ONE / 4), ONE / 8, ONE / 8, ONE / 16);
        loadStage(2, ONE * 5 / 4, ONE / 2, -(ONE / 8), -(ONE * 3 / 8), ONE / 4);
    endtask

    task automatic testReset();
        applyReset();
        checkBit("reset inReady", 1'b1, inReady);
        checkBit("reset outValid", 1'b0, outValid);
        randomSamples(6, 20000);
        runSamples("reset", 1'b0);
    endtask

    task automatic testPassThrough();
        applyReset();
        loadStage(0, ONE, 0, 0, 0, 0);
        loadStage(1, ONE, 0, 0, 0, 0);
        randomSamples(4, 20000);
        runSamples("pass-through partial", 1'b0);   // Stage 2 still silent
        loadStage(2, ONE, 0, 0, 0, 0);
        randomSamples(16, 30000);
        runSamples("pass-through", 1'b0);
    endtask

    task automatic testImpulse();
        applyReset();
        // Negative a1 needs high bits from the address word
        loadStage(0, ONE / 4, ONE / 2, ONE / 4, -(ONE / 2), ONE / 4);
        loadStage(1, ONE, 0, 0, 0, 0);
        loadStage(2, ONE, 0, 0, 0, 0);
        stimQ.delete();
        stimQ.push_back(sampleT'(16000));
        repeat (15) stimQ.push_back(sampleT'(0));
        runSamples("impulse", 1'b0);
    endtask

    task automatic testCascade();
        applyReset();
        loadCascade();
        randomSamples(40, 8000);
        runSamples("cascade", 1'b0);
    endtask

    task automatic testSaturation();
        applyReset();
        loadStage(0, ONE * 7 / 2, 0, 0, 0, 0);   // Gain of 3.5
        loadStage(1, ONE, 0, 0, 0, 0);
        loadStage(2, ONE, 0, 0, 0, 0);
        stimQ.delete();
        stimQ.push_back(sampleT'(32767));
        stimQ.push_back(sampleT'(-32768));
        stimQ.push_back(sampleT'(20000));
        stimQ.push_back(sampleT'(-12000));
        stimQ.push_back(sampleT'(5000));
        runSamples("saturation", 1'b0);
    endtask

    task automatic testBackPressure();
        applyReset();
        loadCascade();
        randomSamples(20, 8000);
        runSamples("back-pressure", 1'b1);
    endtask

    initial begin
        int assertFails;
        void'($urandom(3));
        sysClk     = 1'b0;
        rst        = 1'b1;
        gpioStrobe = 1'b0;
        gpioData   = '0;
        inData     = '0;
        inValid    = 1'b0;
        outReady   = 1'b1;
        testReset();
        testPassThrough();
        testImpulse();
        testCascade();
        testSaturation();
        testBackPressure();
        assertFails = i_iirFilter.i_checker.violationCount;
        $display("Checks %0d, errors %0d, assertion failures %0d",
                 checkTotal, errorCount, assertFails);
        if (errorCount == 0 && assertFails == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/iirTypesPkg.sv
hdl/gpioCmdPkg.sv
hdl/coefLoader.sv
hdl/coefBank.sv
hdl/biquadStage.sv
hdl/iirFilter.sv
tb/iirFilter_checker.sv
tb/iirFilterTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build the IIR filter testbench with Verilator, run it, and judge the log
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module iirFilterTb \
    -f sources.f \
    -o iirFilterSim

# Keep running past assertion errors so the testbench prints its summary
./obj_dir/iirFilterSim +verilator+error+limit+1000 | tee sim.log

if grep -q "tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi

echo "Simulation finished without failures"
